//--- rtl/pti_pkg.sv
// -------------------------------------
// PTI shared package: bus widths, data
// types and the slave register map
// -------------------------------------
package pti_pkg;

	// Memory address width, also used for the byte counts
	localparam int ADDR_W = 32;

	// Bytes carried by one master bus word
	localparam int WORD_BYTES = 16;

	// One byte as seen on the parallel port
	typedef logic [7:0] byte_t;

	// One master bus word; byte k sits in bits 8k+7 down to 8k
	typedef logic [8*WORD_BYTES-1:0] word_t;

	// Memory address or remaining byte count
	typedef logic [ADDR_W-1:0] addr_t;

	// Register index decoded from slave address bits 6:4
	// Indices 5 and 6 are unused and read back as zero
	typedef enum logic [2:0] {
		REG_DSTADR = 3'd0,
		REG_DSTCNT = 3'd1,
		REG_SRCADR = 3'd2,
		REG_SRCCNT = 3'd3,
		REG_CTRL   = 3'd4,
		REG_STATUS = 3'd7
	} reg_idx_e;

endpackage

//--- rtl/pti_ctrl_if.sv
`timescale 1ns/1ns
// -------------------------------------
// PTI control interface between the
// register block and the datapath
// -------------------------------------
interface pti_ctrl_if;
	import pti_pkg::*;

	// Next memory address for each direction
	addr_t dst_adr;
	addr_t src_adr;

	// Bytes still to move; each step takes one word off
	addr_t dst_cnt;
	addr_t src_cnt;

	// Stream enables, receive toward memory and transmit from memory
	logic rd_stream;
	logic wr_stream;

	// One-cycle pulses from the bus master for a finished write or read word
	logic dst_step;
	logic src_step;

	modport regs (
		output dst_adr, src_adr, dst_cnt, src_cnt, rd_stream, wr_stream,
		input  dst_step, src_step
	);

	modport master (
		input  dst_adr, src_adr,
		output dst_step, src_step
	);

	// The packer only needs to know whether to pull bytes
	modport rx (input rd_stream);

	// The unpacker also watches the source count so it never reads past the end
	modport tx (input wr_stream, src_cnt);

endinterface

//--- rtl/pti_xfer_if.sv
`timescale 1ns/1ns
// -------------------------------------
// PTI transfer interface carrying word
// requests to the bus master
// -------------------------------------
interface pti_xfer_if;
	import pti_pkg::*;

	// Write side, packer to memory
	// wr_req is a level held until wr_done
	logic  wr_req;
	word_t wr_data;
	logic  wr_done;

	// Read side, memory to unpacker
	// rd_data is only meaningful while rd_done is high
	logic  rd_req;
	word_t rd_data;
	logic  rd_done;

	// A requester drops its request on done and keeps it low for one cycle
	modport rx (output wr_req, wr_data, input wr_done);

	modport tx (output rd_req, input rd_data, rd_done);

	modport master (
		input  wr_req, wr_data, rd_req,
		output wr_done, rd_done, rd_data
	);

endinterface

//--- rtl/pti_regs.sv
`timescale 1ns/1ns
// -------------------------------------
// PTI register block: addresses, counts,
// stream enables, interrupts, status
// -------------------------------------
module pti_regs #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic clk,
	input  logic rst_i,
	input  logic cs_i,
	input  logic s_cyc_i,
	input  logic s_stb_i,
	input  logic s_we_i,
	input  logic [7:0] s_sel_i,
	input  logic [7:0] s_adr_i,
	input  logic [63:0] s_dat_i,
	output logic s_ack_o,
	output logic [63:0] s_dat_o,
	pti_ctrl_if.regs ctrl,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] in_count_i,
	input  logic in_empty_i,
	input  logic [$clog2(FIFO_DEPTH+1)-1:0] out_count_i,
	input  logic out_full_i,
	output logic sirq_o,
	output logic dirq_o
);
	import pti_pkg::*;

	localparam int CW = $clog2(FIFO_DEPTH + 1);

	reg_idx_e idx;
	logic     wr;
	logic     wr_word;
	logic     wr_ctrl;
	addr_t    wr_val;
	logic     sirq;
	logic     dirq;
	logic     sirq_en;
	logic     dirq_en;
	logic [63:0] status;

	// The CPU access is acknowledged in the same cycle it is presented
	assign s_ack_o = cs_i && s_cyc_i && s_stb_i;
	assign wr = s_ack_o && s_we_i;
	assign idx = reg_idx_e'(s_adr_i[6:4]);

	// Address and count registers need the whole low 32 bits written
	assign wr_word = wr && (&s_sel_i[3:0]);
	assign wr_ctrl = wr && (idx == REG_CTRL);

	// Transfers are word aligned so the low nibble is dropped
	assign wr_val = {s_dat_i[ADDR_W-1:4], 4'h0};

	// -------------------------------------
	// Address and count registers
	// -------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ctrl.dst_adr <= '0;
			ctrl.dst_cnt <= '0;
			ctrl.src_adr <= '0;
			ctrl.src_cnt <= '0;
		end else begin
			// Each finished word moves the address on and takes a word off the count
			if (ctrl.dst_step) begin
				ctrl.dst_adr <= ctrl.dst_adr + ADDR_W'(WORD_BYTES);
				ctrl.dst_cnt <= ctrl.dst_cnt - ADDR_W'(WORD_BYTES);
			end
			if (ctrl.src_step) begin
				ctrl.src_adr <= ctrl.src_adr + ADDR_W'(WORD_BYTES);
				ctrl.src_cnt <= ctrl.src_cnt - ADDR_W'(WORD_BYTES);
			end
			// A CPU write in the same cycle overrides the step
			if (wr_word && idx == REG_DSTADR)
				ctrl.dst_adr <= wr_val;
			if (wr_word && idx == REG_DSTCNT)
				ctrl.dst_cnt <= wr_val;
			if (wr_word && idx == REG_SRCADR)
				ctrl.src_adr <= wr_val;
			if (wr_word && idx == REG_SRCCNT)
				ctrl.src_cnt <= wr_val;
		end
	end

	// -------------------------------------
	// Control bits and interrupt flags
	// -------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ctrl.rd_stream <= 1'b0;
			ctrl.wr_stream <= 1'b0;
			sirq_en <= 1'b0;
			dirq_en <= 1'b0;
			sirq <= 1'b0;
			dirq <= 1'b0;
		end else begin
			// Receive streaming stops by itself once the last word is written
			if (ctrl.dst_step && ctrl.dst_cnt == ADDR_W'(WORD_BYTES))
				ctrl.rd_stream <= 1'b0;
			if (wr_ctrl && s_sel_i[0])
				ctrl.rd_stream <= s_dat_i[0];
			// Transmit streaming is only ever changed by the CPU
			if (wr_ctrl && s_sel_i[1])
				ctrl.wr_stream <= s_dat_i[8];
			if (wr_ctrl && s_sel_i[4])
				sirq_en <= s_dat_i[32];
			if (wr_ctrl && s_sel_i[5])
				dirq_en <= s_dat_i[40];
			// Flags stick while a count sits at zero; any control write clears them
			if (ctrl.src_cnt == '0)
				sirq <= 1'b1;
			if (ctrl.dst_cnt == '0)
				dirq <= 1'b1;
			if (wr_ctrl) begin
				sirq <= 1'b0;
				dirq <= 1'b0;
			end
		end
	end

	assign sirq_o = sirq && sirq_en;
	assign dirq_o = dirq && dirq_en;

	// Status word, input FIFO in the low half and output FIFO above it
	always_comb begin
		status = '0;
		status[CW-1:0] = in_count_i;
		status[15] = in_empty_i;
		status[16 +: CW] = out_count_i;
		status[31] = out_full_i;
	end

	// Read data is registered, so a read shows up the cycle after its address
	always_ff @(posedge clk) begin
		if (rst_i) begin
			s_dat_o <= '0;
		end else begin
			case (idx)
				REG_DSTADR: s_dat_o <= {32'h0, ctrl.dst_adr};
				REG_DSTCNT: s_dat_o <= {32'h0, ctrl.dst_cnt};
				REG_SRCADR: s_dat_o <= {32'h0, ctrl.src_adr};
				REG_SRCCNT: s_dat_o <= {32'h0, ctrl.src_cnt};
				REG_CTRL: s_dat_o <= {23'h0, dirq_en, 7'h0, sirq_en,
					23'h0, ctrl.wr_stream, 7'h0, ctrl.rd_stream};
				REG_STATUS: s_dat_o <= status;
				default: s_dat_o <= '0;
			endcase
		end
	end

	// The datapath must never finish a word once its count has run out
	a_dst_step_cnt: assert property (@(posedge clk) disable iff (rst_i)
		ctrl.dst_step |-> ctrl.dst_cnt != '0)
		else $error("destination word completed with zero count");

	a_src_step_cnt: assert property (@(posedge clk) disable iff (rst_i)
		ctrl.src_step |-> ctrl.src_cnt != '0)
		else $error("source word completed with zero count");

endmodule

//--- rtl/pti_byte_fifo.sv
`timescale 1ns/1ns
// -------------------------------------
// Synchronous byte FIFO, fall-through
// output with fill count and flags
// -------------------------------------
module pti_byte_fifo #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic clk,
	input  logic rst_i,
	input  logic push_i,
	input  pti_pkg::byte_t din_i,
	input  logic pop_i,
	output pti_pkg::byte_t dout_o,
	output logic empty_o,
	output logic full_o,
	output logic afull_o,
	output logic [$clog2(FIFO_DEPTH+1)-1:0] count_o
);
	import pti_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	byte_t mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	// A push into a full FIFO is dropped
	assign do_push = push_i && !full_o;
	assign do_pop = pop_i && !empty_o;

	// Storage has no reset, only the pointers do
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// Pointers wrap at the depth, which need not be a power of two
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	// Head byte is visible before it is popped
	assign dout_o = mem[rd_ptr];
	assign count_o = count;
	assign empty_o = (count == '0);
	assign full_o = (count == CW'(FIFO_DEPTH));
	// Leaves a few slots for writers with a pipelined push
	assign afull_o = (count >= CW'(FIFO_DEPTH - 4));

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
		pop_i |-> !empty_o)
		else $error("pop from an empty FIFO");

endmodule

//--- rtl/pti_rx_packer.sv
`timescale 1ns/1ns
// -------------------------------------
// Receive packer: gathers input bytes
// into 128-bit words, two halves deep
// -------------------------------------
module pti_rx_packer (
	input  logic clk,
	input  logic rst_i,
	output logic pop_o,
	input  pti_pkg::byte_t din_i,
	input  logic empty_i,
	pti_ctrl_if.rx ctrl,
	pti_xfer_if.rx xfer
);
	import pti_pkg::*;

	// 32 bytes, the index MSB picks the half being filled
	byte_t bytes_q [2*WORD_BYTES];
	logic [4:0] idx;
	// One bit per half, set while that half waits for its memory write
	logic [1:0] busy;
	// Half that is next in line for the bus master
	logic wr_half;

	// Pull a byte whenever streaming is on, one is ready and the target half is free
	assign pop_o = ctrl.rd_stream && !empty_i && !busy[idx[4]];

	always_ff @(posedge clk) begin
		if (pop_o)
			bytes_q[idx] <= din_i;
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			idx <= '0;
			busy <= '0;
			wr_half <= 1'b0;
			xfer.wr_req <= 1'b0;
		end else begin
			if (pop_o)
				idx <= idx + 1'b1;
			// Sixteenth byte of a half hands it over to the master
			if (pop_o && idx[3:0] == 4'hf)
				busy[idx[4]] <= 1'b1;
			// Written half becomes free and the other one is next
			if (xfer.wr_done) begin
				busy[wr_half] <= 1'b0;
				wr_half <= ~wr_half;
			end
			// Request drops on done and can only come back a cycle later
			if (xfer.wr_done)
				xfer.wr_req <= 1'b0;
			else if (busy[wr_half])
				xfer.wr_req <= 1'b1;
		end
	end

	// First byte of the half lands in the lowest lane of the word
	always_comb begin
		for (int k = 0; k < WORD_BYTES; k++) begin
			xfer.wr_data[8*k +: 8] = bytes_q[{wr_half, 4'(k)}];
		end
	end

endmodule

//--- rtl/pti_tx_unpacker.sv
`timescale 1ns/1ns
// -------------------------------------
// Transmit unpacker splitting memory
// words into bytes for the output FIFO
// -------------------------------------
module pti_tx_unpacker (
	input  logic clk,
	input  logic rst_i,
	output logic push_o,
	output pti_pkg::byte_t dout_o,
	input  logic afull_i,
	pti_ctrl_if.tx ctrl,
	pti_xfer_if.tx xfer
);
	import pti_pkg::*;

	// Two word buffers so one can be read from memory while the other drains
	word_t word_q [2];
	logic [1:0] valid;
	// Buffer that takes the next read word
	logic load_ptr;
	// Buffer currently being emitted
	logic out_ptr;
	logic [3:0] byte_idx;
	logic emit;

	// Stall while the output FIFO is close to full
	assign emit = valid[out_ptr] && !afull_i;

	// Word buffers fill on each read and the output byte follows the drain
	always_ff @(posedge clk) begin
		if (xfer.rd_done)
			word_q[load_ptr] <= xfer.rd_data;
		// Low byte goes out first
		if (emit)
			dout_o <= word_q[out_ptr][{byte_idx, 3'b000} +: 8];
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			push_o <= 1'b0;
			valid <= '0;
			load_ptr <= 1'b0;
			out_ptr <= 1'b0;
			byte_idx <= '0;
			xfer.rd_req <= 1'b0;
		end else begin
			// Push is registered together with its byte
			push_o <= emit;
			if (emit) begin
				byte_idx <= byte_idx + 1'b1;
				// After byte 15 the buffer is empty again
				if (byte_idx == 4'hf) begin
					valid[out_ptr] <= 1'b0;
					out_ptr <= ~out_ptr;
				end
			end
			// The loaded buffer is always a free one and never clashes with the drain
			if (xfer.rd_done) begin
				valid[load_ptr] <= 1'b1;
				load_ptr <= ~load_ptr;
			end
			// Ask for a word while a buffer is free and the source count has words left
			if (xfer.rd_done)
				xfer.rd_req <= 1'b0;
			else if (!valid[load_ptr] && ctrl.wr_stream && ctrl.src_cnt != '0)
				xfer.rd_req <= 1'b1;
		end
	end

	// A read word may only land in a buffer that has already drained
	a_rd_into_free: assert property (@(posedge clk) disable iff (rst_i)
		xfer.rd_done |-> !valid[load_ptr])
		else $error("read word arrived with no free buffer");

endmodule

//--- rtl/pti_bus_master.sv
`timescale 1ns/1ns
// -------------------------------------
// Bus master issuing one 128-bit cycle
// at a time and serving writes first
// -------------------------------------
module pti_bus_master (
	input  logic clk,
	input  logic rst_i,
	output logic m_cyc_o,
	output logic m_stb_o,
	output logic m_we_o,
	output logic [pti_pkg::WORD_BYTES-1:0] m_sel_o,
	output pti_pkg::addr_t m_adr_o,
	output pti_pkg::word_t m_dat_o,
	input  pti_pkg::word_t m_dat_i,
	input  logic m_ack_i,
	pti_ctrl_if.master ctrl,
	pti_xfer_if.master xfer
);
	logic ack;
	logic start;

	// Acknowledge only counts while our cycle is open
	assign ack = m_cyc_o && m_ack_i;
	// A new cycle can begin only from idle
	assign start = !m_cyc_o && (xfer.wr_req || xfer.rd_req);

	// Strobe follows the cycle and all byte lanes are always used
	assign m_stb_o = m_cyc_o;
	assign m_sel_o = '1;

	// Done and step pulses come out in the acknowledge cycle itself
	assign xfer.wr_done = ack && m_we_o;
	assign xfer.rd_done = ack && !m_we_o;
	assign xfer.rd_data = m_dat_i;
	assign ctrl.dst_step = xfer.wr_done;
	assign ctrl.src_step = xfer.rd_done;

	// -------------------------------------
	// Cycle control
	// -------------------------------------
	always_ff @(posedge clk) begin
		if (rst_i) begin
			m_cyc_o <= 1'b0;
			m_we_o <= 1'b0;
		end else if (start) begin
			m_cyc_o <= 1'b1;
			// Write wins when both are pending
			m_we_o <= xfer.wr_req;
		end else if (ack) begin
			m_cyc_o <= 1'b0;
			m_we_o <= 1'b0;
		end
	end

	// Address and data are captured once and held for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			m_adr_o <= xfer.wr_req ? ctrl.dst_adr : ctrl.src_adr;
			m_dat_o <= xfer.wr_data;
		end
	end

	// An open cycle always belongs to a request still waiting for its done pulse
	a_cyc_has_req: assert property (@(posedge clk) disable iff (rst_i)
		m_cyc_o |-> (m_we_o ? xfer.wr_req : xfer.rd_req))
		else $error("bus cycle open without a pending request");

endmodule

//--- rtl/pti_top.sv
`timescale 1ns/1ns
// -------------------------------------
// PTI top: byte port to 128-bit memory
// DMA bridge with CPU register slave
// -------------------------------------
module pti_top #(
	parameter int FIFO_DEPTH = 64
) (
	input  logic clk,
	input  logic rst_i,
	// Byte port
	input  logic rx_valid_i,
	input  pti_pkg::byte_t rx_data_i,
	output logic rx_full_o,
	output logic tx_valid_o,
	output pti_pkg::byte_t tx_data_o,
	input  logic tx_take_i,
	// CPU slave bus
	input  logic cs_i,
	input  logic s_cyc_i,
	input  logic s_stb_i,
	input  logic s_we_i,
	input  logic [7:0] s_sel_i,
	input  logic [7:0] s_adr_i,
	input  logic [63:0] s_dat_i,
	output logic s_ack_o,
	output logic [63:0] s_dat_o,
	// Memory master bus
	output logic m_cyc_o,
	output logic m_stb_o,
	output logic m_we_o,
	output logic [pti_pkg::WORD_BYTES-1:0] m_sel_o,
	output pti_pkg::addr_t m_adr_o,
	output pti_pkg::word_t m_dat_o,
	input  pti_pkg::word_t m_dat_i,
	input  logic m_ack_i,
	// Interrupts
	output logic sirq_o,
	output logic dirq_o
);
	import pti_pkg::*;

	localparam int CW = $clog2(FIFO_DEPTH + 1);

	pti_ctrl_if ctrl ();
	pti_xfer_if xfer ();

	logic in_pop;
	byte_t in_dout;
	logic in_empty;
	logic in_full;
	logic [CW-1:0] in_count;
	logic out_push;
	byte_t out_din;
	logic out_empty;
	logic out_full;
	logic out_afull;
	logic [CW-1:0] out_count;

	// Port flags come straight from the FIFOs
	assign rx_full_o = in_full;
	assign tx_valid_o = !out_empty;

	pti_regs #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs (
		.clk, .rst_i, .cs_i, .s_cyc_i, .s_stb_i, .s_we_i, .s_sel_i, .s_adr_i,
		.s_dat_i, .s_ack_o, .s_dat_o, .ctrl(ctrl.regs),
		.in_count_i(in_count), .in_empty_i(in_empty),
		.out_count_i(out_count), .out_full_i(out_full), .sirq_o, .dirq_o
	);

	// Receive side, port into packer
	pti_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
		.clk, .rst_i, .push_i(rx_valid_i), .din_i(rx_data_i), .pop_i(in_pop),
		.dout_o(in_dout), .empty_o(in_empty), .full_o(in_full), .afull_o(),
		.count_o(in_count)
	);

	pti_rx_packer u_rx_packer (
		.clk, .rst_i, .pop_o(in_pop), .din_i(in_dout), .empty_i(in_empty),
		.ctrl(ctrl.rx), .xfer(xfer.rx)
	);

	// Transmit side, unpacker out to the port
	pti_tx_unpacker u_tx_unpacker (
		.clk, .rst_i, .push_o(out_push), .dout_o(out_din), .afull_i(out_afull),
		.ctrl(ctrl.tx), .xfer(xfer.tx)
	);

	pti_byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_out_fifo (
		.clk, .rst_i, .push_i(out_push), .din_i(out_din), .pop_i(tx_take_i),
		.dout_o(tx_data_o), .empty_o(out_empty), .full_o(out_full),
		.afull_o(out_afull), .count_o(out_count)
	);

	pti_bus_master u_bus_master (
		.clk, .rst_i, .m_cyc_o, .m_stb_o, .m_we_o, .m_sel_o, .m_adr_o, .m_dat_o,
		.m_dat_i, .m_ack_i, .ctrl(ctrl.master), .xfer(xfer.master)
	);

endmodule

//--- test/pti_tb.sv
`timescale 1ns/1ns
// ----------------------------------------
// PTI testbench driving random byte streams
// with CPU, memory and port models
// ----------------------------------------
module pti_tb;
	import pti_pkg::*;

	localparam int FIFO_DEPTH = 64;
	localparam int MAX_WORDS = 6;
	// Receive, FIFO full, transmit and the concurrent pair each move up to MAX_WORDS per path
	localparam int TOTAL_BYTES = 5 * MAX_WORDS * WORD_BYTES;
	// Worst case covers long acknowledge waits and a slow taker
	localparam int CYCLES_PER_BYTE = 16;
	localparam int CYCLE_LIMIT = TOTAL_BYTES * CYCLES_PER_BYTE + 3000;

	logic clk;
	logic rst_i;
	logic rx_valid_i;
	byte_t rx_data_i;
	logic rx_full_o;
	logic tx_valid_o;
	byte_t tx_data_o;
	logic tx_take_i;
	logic cs_i;
	logic s_cyc_i;
	logic s_stb_i;
	logic s_we_i;
	logic [7:0] s_sel_i;
	logic [7:0] s_adr_i;
	logic [63:0] s_dat_i;
	logic s_ack_o;
	logic [63:0] s_dat_o;
	logic m_cyc_o;
	logic m_stb_o;
	logic m_we_o;
	logic [WORD_BYTES-1:0] m_sel_o;
	addr_t m_adr_o;
	word_t m_dat_o;
	word_t m_dat_i;
	logic m_ack_i;
	logic sirq_o;
	logic dirq_o;

	integer seed = 60710;
	int errors = 0;
	int cycles = 0;
	string test_name = "init";

	// Bytes sent on the port and not yet seen in a memory write
	byte_t rx_q [$];
	// Bytes expected on the port in address order with the low byte first
	byte_t tx_q [$];
	word_t mem [addr_t];
	addr_t rx_base;
	addr_t tx_base;
	int rx_words = 0;
	int tx_words = 0;
	int wr_count = 0;
	int rd_count = 0;
	int words_written = 0;
	int words_read = 0;
	int rx_left = 0;
	int tx_got = 0;
	// A byte is taken when the random value masked by this is zero
	int take_mask = 1;

	pti_top #(.FIFO_DEPTH(FIFO_DEPTH)) DUT (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic wrong_value(input string what, input word_t exp, input word_t act);
		$display("MISMATCH %s %s: expected %0h actual %0h", test_name, what, exp, act);
		errors++;
	endtask

	task automatic flag_problem(input string what);
		$display("ERROR in %s: %s", test_name, what);
		errors++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// ----------------------------------------
	// CPU slave accesses
	// ----------------------------------------
	task automatic cpu_write(input logic [2:0] idx, input logic [63:0] data);
		cs_i = 1'b1;
		s_cyc_i = 1'b1;
		s_stb_i = 1'b1;
		s_we_i = 1'b1;
		s_sel_i = 8'hff;
		s_adr_i = {1'b0, idx, 4'h0};
		s_dat_i = data;
		@(posedge clk);
		if (!s_ack_o)
			flag_problem("slave write was not acknowledged");
		#1;
		cs_i = 1'b0;
		s_cyc_i = 1'b0;
		s_stb_i = 1'b0;
		s_we_i = 1'b0;
	endtask

	// Registered read data means the access is held two cycles and sampled in the second
	task automatic cpu_read(input logic [2:0] idx, output logic [63:0] data);
		cs_i = 1'b1;
		s_cyc_i = 1'b1;
		s_stb_i = 1'b1;
		s_we_i = 1'b0;
		s_adr_i = {1'b0, idx, 4'h0};
		@(posedge clk);
		if (!s_ack_o)
			flag_problem("slave read was not acknowledged");
		@(posedge clk);
		#1;
		data = s_dat_o;
		cs_i = 1'b0;
		s_cyc_i = 1'b0;
		s_stb_i = 1'b0;
	endtask

	// ----------------------------------------
	// Port models
	// ----------------------------------------
	// Sender pushes at about three bytes in four while the input FIFO has room
	initial begin
		rx_valid_i = 1'b0;
		rx_data_i = '0;
		forever begin
			@(posedge clk);
			#1;
			rx_valid_i = 1'b0;
			if (rx_left > 0 && !rx_full_o && ($random(seed) & 3) != 0) begin
				rx_valid_i = 1'b1;
				rx_data_i = $random(seed);
				rx_q.push_back(rx_data_i);
				rx_left--;
			end
		end
	end

	// Receiver takes the head byte at a random rate and checks it in order
	initial begin
		byte_t exp_b;
		tx_take_i = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			tx_take_i = 1'b0;
			if (tx_valid_o && ($random(seed) & take_mask) == 0) begin
				tx_take_i = 1'b1;
				tx_got++;
				if (tx_q.size() == 0) begin
					flag_problem("port delivered a byte beyond the source count");
				end else begin
					exp_b = tx_q.pop_front();
					if (tx_data_o !== exp_b)
						wrong_value("port byte", exp_b, tx_data_o);
				end
			end
		end
	end

	// ----------------------------------------
	// Memory model with 0 to 5 wait cycles
	// ----------------------------------------
	initial begin
		word_t exp_w;
		int wait_n;
		m_ack_i = 1'b0;
		m_dat_i = '0;
		forever begin
			@(posedge clk);
			#1;
			if (m_cyc_o) begin
				wait_n = $unsigned($random(seed)) % 6;
				repeat (wait_n) begin
					@(posedge clk);
					#1;
				end
				if (m_stb_o !== 1'b1 || m_sel_o !== '1)
					flag_problem("strobe or byte selects not fully set during a cycle");
				if (m_we_o) begin
					if (wr_count >= rx_words)
						flag_problem("memory write beyond the destination count");
					if (m_adr_o !== rx_base + 16 * wr_count)
						wrong_value("write address", rx_base + 16 * wr_count, m_adr_o);
					if (rx_q.size() < WORD_BYTES) begin
						flag_problem("memory write before its 16 bytes were sent");
					end else begin
						// First byte sent sits in bits 7:0
						for (int k = 0; k < WORD_BYTES; k++)
							exp_w[8*k +: 8] = rx_q.pop_front();
						if (m_dat_o !== exp_w)
							wrong_value("write data", exp_w, m_dat_o);
					end
					mem[m_adr_o] = m_dat_o;
					wr_count++;
					words_written++;
				end else begin
					if (rd_count >= tx_words)
						flag_problem("memory read beyond the source count");
					if (m_adr_o !== tx_base + 16 * rd_count)
						wrong_value("read address", tx_base + 16 * rd_count, m_adr_o);
					if (mem.exists(m_adr_o)) begin
						m_dat_i = mem[m_adr_o];
					end else begin
						flag_problem("memory read from an address that was never loaded");
						m_dat_i = '0;
					end
					rd_count++;
					words_read++;
				end
				m_ack_i = 1'b1;
				@(posedge clk);
				#1;
				m_ack_i = 1'b0;
			end
		end
	end

	// Watchdog ends the run once the cycle budget is spent
	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles, errors %0d", cycles, errors);
		$display("** FAIL **");
		$finish;
	end

	// ----------------------------------------
	// Test setup and completion checks
	// ----------------------------------------
	task automatic setup_rx(input int n);
		rx_base = 32'h1000_0000 | ($random(seed) & 32'h00ff_fff0);
		rx_words = n;
		wr_count = 0;
		cpu_write(REG_DSTADR, {32'h0, rx_base});
		cpu_write(REG_DSTCNT, n * WORD_BYTES);
		rx_left = n * WORD_BYTES;
	endtask

	// Memory is loaded before the stream starts and the expected bytes are queued with it
	task automatic setup_tx(input int m);
		word_t w;
		tx_base = 32'h2000_0000 | ($random(seed) & 32'h00ff_fff0);
		tx_words = m;
		rd_count = 0;
		tx_got = 0;
		for (int i = 0; i < m; i++) begin
			w = {$random(seed), $random(seed), $random(seed), $random(seed)};
			mem[tx_base + 16 * i] = w;
			for (int k = 0; k < WORD_BYTES; k++)
				tx_q.push_back(w[8*k +: 8]);
		end
		cpu_write(REG_SRCADR, {32'h0, tx_base});
		cpu_write(REG_SRCCNT, m * WORD_BYTES);
	endtask

	task automatic check_rx_done();
		logic [63:0] rd;
		wait_cycles(30);
		if (wr_count != rx_words)
			wrong_value("words written", rx_words, wr_count);
		if (rx_q.size() != 0)
			flag_problem("sent bytes never reached memory");
		cpu_read(REG_CTRL, rd);
		if (rd[0] !== 1'b0)
			wrong_value("rd_stream", 0, rd[0]);
		cpu_read(REG_DSTCNT, rd);
		if (rd !== 64'h0)
			wrong_value("destination count", 0, rd);
	endtask

	task automatic check_tx_done();
		logic [63:0] rd;
		wait_cycles(40);
		if (tx_valid_o !== 1'b0)
			wrong_value("tx_valid_o after last byte", 0, tx_valid_o);
		if (rd_count != tx_words)
			wrong_value("words read", tx_words, rd_count);
		if (tx_q.size() != 0)
			flag_problem("source bytes never delivered on the port");
		cpu_read(REG_SRCCNT, rd);
		if (rd !== 64'h0)
			wrong_value("source count", 0, rd);
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial begin
		logic [63:0] rd;
		logic [63:0] d;
		addr_t val;
		int n;
		int m;
		rst_i = 1'b1;
		cs_i = 1'b0;
		s_cyc_i = 1'b0;
		s_stb_i = 1'b0;
		s_we_i = 1'b0;
		s_sel_i = '0;
		s_adr_i = '0;
		s_dat_i = '0;
		repeat (5) @(posedge clk);
		#1;
		rst_i = 1'b0;

		test_name = "reset";
		if (m_cyc_o !== 1'b0)
			wrong_value("m_cyc_o", 0, m_cyc_o);
		if (m_stb_o !== 1'b0 || m_we_o !== 1'b0)
			flag_problem("master strobe or write enable high after reset");
		if (sirq_o !== 1'b0)
			wrong_value("sirq_o", 0, sirq_o);
		if (dirq_o !== 1'b0)
			wrong_value("dirq_o", 0, dirq_o);
		if (tx_valid_o !== 1'b0)
			wrong_value("tx_valid_o", 0, tx_valid_o);
		// Indices 5 and 6 are unused and must also read zero
		for (int i = 0; i < 7; i++) begin
			cpu_read(3'(i), rd);
			if (rd !== 64'h0)
				wrong_value($sformatf("register %0d", i), 0, rd);
		end

		test_name = "readback";
		for (int i = 0; i < 8; i++) begin
			for (int r = 0; r < 4; r++) begin
				val = $random(seed);
				cpu_write(3'(r), {$random(seed), val});
				cpu_read(3'(r), rd);
				if (rd !== {32'h0, val[31:4], 4'h0})
					wrong_value($sformatf("register %0d", r), {val[31:4], 4'h0}, rd);
			end
		end
		// Source count zero keeps a random wr_stream from starting reads
		cpu_write(REG_SRCCNT, 64'h0);
		for (int i = 0; i < 8; i++) begin
			d = {$random(seed), $random(seed)};
			cpu_write(REG_CTRL, d);
			cpu_read(REG_CTRL, rd);
			if (rd !== (d & 64'h0000_0101_0000_0101))
				wrong_value("control", d & 64'h0000_0101_0000_0101, rd);
		end
		cpu_write(REG_CTRL, 64'h0);

		test_name = "receive";
		n = 1 + $unsigned($random(seed)) % MAX_WORDS;
		setup_rx(n);
		cpu_write(REG_CTRL, 64'h1);
		while (wr_count < n)
			@(posedge clk);
		#1;
		check_rx_done();

		// Input FIFO fills while receive streaming is off and then drains into memory
		test_name = "fifo full";
		n = FIFO_DEPTH / WORD_BYTES + 1;
		setup_rx(n);
		while (rx_q.size() < FIFO_DEPTH)
			@(posedge clk);
		wait_cycles(2);
		if (rx_full_o !== 1'b1)
			wrong_value("rx_full_o with a full input FIFO", 1, rx_full_o);
		cpu_write(REG_CTRL, 64'h1);
		while (wr_count < n)
			@(posedge clk);
		#1;
		check_rx_done();

		test_name = "transmit";
		m = 1 + $unsigned($random(seed)) % MAX_WORDS;
		setup_tx(m);
		cpu_write(REG_CTRL, 64'h100);
		while (tx_got < m * WORD_BYTES)
			@(posedge clk);
		#1;
		check_tx_done();
		cpu_write(REG_CTRL, 64'h0);

		// Slower taker fills the output FIFO so the unpacker has to stall
		test_name = "concurrent";
		take_mask = 3;
		n = 1 + $unsigned($random(seed)) % MAX_WORDS;
		m = 1 + $unsigned($random(seed)) % MAX_WORDS;
		setup_rx(n);
		setup_tx(m);
		cpu_write(REG_CTRL, 64'h101);
		while (wr_count < n || tx_got < m * WORD_BYTES)
			@(posedge clk);
		#1;
		check_rx_done();
		check_tx_done();
		cpu_write(REG_CTRL, 64'h0);

		// Both counts are at zero here and both sticky flags are already set
		test_name = "interrupt";
		wait_cycles(4);
		if (sirq_o !== 1'b0)
			wrong_value("sirq_o with enable off", 0, sirq_o);
		if (dirq_o !== 1'b0)
			wrong_value("dirq_o with enable off", 0, dirq_o);
		cpu_write(REG_CTRL, 64'h0000_0101_0000_0000);
		wait_cycles(3);
		if (sirq_o !== 1'b1)
			wrong_value("sirq_o with enable on", 1, sirq_o);
		if (dirq_o !== 1'b1)
			wrong_value("dirq_o with enable on", 1, dirq_o);
		// Non-zero counts keep the flags from setting again after the clear
		cpu_write(REG_DSTCNT, 64'h10);
		cpu_write(REG_SRCCNT, 64'h10);
		cpu_write(REG_CTRL, 64'h0000_0101_0000_0000);
		wait_cycles(3);
		if (sirq_o !== 1'b0)
			wrong_value("sirq_o after control write", 0, sirq_o);
		if (dirq_o !== 1'b0)
			wrong_value("dirq_o after control write", 0, dirq_o);
		cpu_write(REG_CTRL, 64'h0);

		$display("Errors %0d, words written %0d, words read %0d, cycles %0d",
			errors, words_written, words_read, cycles);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- pti.f
rtl/pti_pkg.sv
rtl/pti_ctrl_if.sv
rtl/pti_xfer_if.sv
rtl/pti_regs.sv
rtl/pti_byte_fifo.sv
rtl/pti_rx_packer.sv
rtl/pti_tx_unpacker.sv
rtl/pti_bus_master.sv
rtl/pti_top.sv
test/pti_tb.sv
